// ==== build.f ====
+incdir+.
npc_pkg.sv
npc_ifu.sv
npc_idu.sv
npc_exu.sv
npc_lsu.sv
npc_gpr.sv
npc_core.sv
npc_checker.sv
npc_asserts.sv
tb_npc.sv

// ==== npc_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_asserts (
  input logic              clk,
  input logic              rst,
  input npc_pkg::apb_req_t apb_req,
  input npc_pkg::apb_rsp_t apb_rsp,
  input logic              imem_en,
  input logic              halt
);

  int failures;

  // access phase only after a setup cycle
  assert property (@(posedge clk) disable iff (rst)
    $rose(apb_req.penable) |-> $past(apb_req.psel && !apb_req.penable))
    else begin
      failures++;
      $error("penable rose without a setup cycle");
    end

  assert property (@(posedge clk) disable iff (rst)
    (apb_req.psel && !(apb_req.penable && apb_rsp.pready)) |=>
      $stable({apb_req.paddr, apb_req.pwrite, apb_req.pwdata, apb_req.pstrb}) && apb_req.psel)
    else begin
      failures++;
      $error("APB request changed before pready");
    end

  assert property (@(posedge clk) disable iff (rst)
    !(halt && (imem_en || apb_req.psel)))
    else begin
      failures++;
      $error("fetch or APB activity while halted");
    end

  assert property (@(posedge clk) $fell(halt) |-> $past(rst))
    else begin
      failures++;
      $error("halt fell without reset");
    end

endmodule

bind npc_core npc_asserts i_npc_asserts (
  .clk     (clk),
  .rst     (rst),
  .apb_req (apb_req),
  .apb_rsp (apb_rsp),
  .imem_en (imem_en),
  .halt    (halt)
);

`default_nettype wire

// ==== npc_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_checker (
  input  logic              clk,
  input  logic              rst,
  input  npc_pkg::apb_req_t apb_req,
  input  npc_pkg::apb_rsp_t apb_rsp,
  input  logic              halt
);

  import npc_pkg::*;

  string       exp_name[$];
  logic [31:0] exp_addr[$];
  logic [31:0] exp_data[$];
  logic [3:0]  exp_strb[$];
  int          idx;
  int          errors;
  int          pass_count;
  int          fail_count;
  bit          test_bad;

  initial begin
    idx        = 0;
    errors     = 0;
    pass_count = 0;
    fail_count = 0;
    test_bad   = 1'b0;
  end

  task automatic expect_store(input string name, input logic [31:0] addr,
                              input logic [31:0] data, input logic [3:0] strb);
    exp_name.push_back(name);
    exp_addr.push_back(addr);
    exp_data.push_back(data);
    exp_strb.push_back(strb);
  endtask

  function automatic logic [31:0] lane_mask(input logic [3:0] strb);
    return {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
  endfunction

  task automatic check_store(input apb_req_t req);
    logic [31:0] mask;
    bit          last;
    if (idx >= exp_addr.size()) begin
      errors++;
      $display("unexpected extra store to %h with data %h", req.paddr, req.pwdata);
    end else begin
      mask = lane_mask(req.pstrb);
      if (req.paddr !== exp_addr[idx] || req.pstrb !== exp_strb[idx] ||
          (req.pwdata & mask) !== exp_data[idx]) begin
        errors++;
        test_bad = 1'b1;
        $display("ERROR %s: expected addr %h data %h strb %h, actual addr %h data %h strb %h",
                 exp_name[idx], exp_addr[idx], exp_data[idx], exp_strb[idx],
                 req.paddr, req.pwdata & mask, req.pstrb);
      end
      last = (idx + 1 == exp_addr.size()) || (exp_name[idx + 1] != exp_name[idx]);
      if (last) begin
        if (test_bad) fail_count++;
        else pass_count++;
        $display("test %s: %s", exp_name[idx], test_bad ? "failed" : "passed");
        test_bad = 1'b0;
      end
      idx++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst) begin
      if (halt && apb_req.psel) begin
        errors++;
        $display("an APB transfer was started after halt");
      end
      if (apb_req.psel && apb_req.penable && apb_rsp.pready && apb_req.pwrite) begin
        check_store(apb_req);
      end
    end
  end

  // anything left in the list never arrived
  task automatic report();
    int i;
    if (idx < exp_addr.size()) begin
      errors++;
      $display("%0d expected stores never happened", exp_addr.size() - idx);
      for (i = idx; i < exp_addr.size(); i++) begin
        if (i + 1 == exp_addr.size() || exp_name[i + 1] != exp_name[i]) begin
          fail_count++;
          $display("test %s: failed, stores missing", exp_name[i]);
        end
      end
    end
    $display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
  endtask

endmodule

`default_nettype wire

// ==== npc_core.sv ====
`timescale 1ns/1ps
`include "npc_defines.svh"
`default_nettype none

module npc_core (
  input  logic              clk,
  input  logic              rst,
  output logic              imem_en,
  output logic [31:0]       imem_addr,
  input  logic [31:0]       imem_rdata,
  output npc_pkg::apb_req_t apb_req,
  input  npc_pkg::apb_rsp_t apb_rsp,
  output logic              halt
);

  import npc_pkg::*;

  typedef enum logic [1:0] {
    ST_FETCH,
    ST_EXEC,
    ST_MEM,
    ST_HALT
  } core_state_e;

  core_state_e state;
  logic [31:0] pc;
  logic [31:0] inst;
  decode_t     dec;
  logic [31:0] src1;
  logic [31:0] src2;
  logic [31:0] alu_result;
  logic [31:0] npc;
  logic [31:0] wb_data;
  logic [31:0] load_data;
  logic        lsu_done;
  logic        exec;
  logic        is_mem;
  logic        retire;

  assign exec   = (state == ST_EXEC);
  assign is_mem = dec.mem_read || dec.mem_write;
  // plain ops finish in execute, memory ops when the lsu sees pready
  assign retire = (exec && !is_mem && !dec.ebreak) || lsu_done;
  assign halt   = (state == ST_HALT);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_FETCH;
      pc    <= `NPC_RESET_PC;
    end else begin
      if (retire) begin
        pc <= npc;
      end
      case (state)
        ST_FETCH: state <= ST_EXEC;
        ST_EXEC: begin
          if (dec.ebreak) state <= ST_HALT;
          else if (is_mem) state <= ST_MEM;
          else state <= ST_FETCH;
        end
        ST_MEM:  if (lsu_done) state <= ST_FETCH;
        default: state <= ST_HALT;
      endcase
    end
  end

  npc_ifu i_npc_ifu (
    .clk        (clk),
    .rst        (rst),
    .fetch      (state == ST_FETCH),
    .pc         (pc),
    .imem_en    (imem_en),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .inst       (inst)
  );

  npc_idu i_npc_idu (
    .inst (inst),
    .dec  (dec)
  );

  npc_exu i_npc_exu (
    .pc         (pc),
    .dec        (dec),
    .src1       (src1),
    .src2       (src2),
    .load_data  (load_data),
    .alu_result (alu_result),
    .npc        (npc),
    .wb_data    (wb_data)
  );

  npc_lsu i_npc_lsu (
    .clk        (clk),
    .rst        (rst),
    .start      (exec && is_mem),
    .dec        (dec),
    .addr       (alu_result),
    .store_data (src2),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .load_data  (load_data),
    .done       (lsu_done)
  );

  npc_gpr i_npc_gpr (
    .clk   (clk),
    .rst   (rst),
    .rs1   (dec.rs1),
    .rs2   (dec.rs2),
    .rd    (dec.rd),
    .wen   (dec.reg_wen && retire),
    .wdata (wb_data),
    .src1  (src1),
    .src2  (src2)
  );

endmodule

`default_nettype wire

// ==== npc_defines.svh ====
`ifndef NPC_DEFINES_SVH
`define NPC_DEFINES_SVH

`define NPC_RESET_PC 32'h8000_0000

// major opcodes
`define NPC_OP_LUI    7'b0110111
`define NPC_OP_AUIPC  7'b0010111
`define NPC_OP_JAL    7'b1101111
`define NPC_OP_JALR   7'b1100111
`define NPC_OP_BRANCH 7'b1100011
`define NPC_OP_LOAD   7'b0000011
`define NPC_OP_STORE  7'b0100011
`define NPC_OP_IMM    7'b0010011
`define NPC_OP_REG    7'b0110011
`define NPC_OP_SYSTEM 7'b1110011

// branch funct3
`define NPC_F3_BEQ  3'b000
`define NPC_F3_BNE  3'b001
`define NPC_F3_BLT  3'b100
`define NPC_F3_BGE  3'b101
`define NPC_F3_BLTU 3'b110
`define NPC_F3_BGEU 3'b111

// load and store funct3
`define NPC_F3_LB  3'b000
`define NPC_F3_LH  3'b001
`define NPC_F3_LW  3'b010
`define NPC_F3_LBU 3'b100
`define NPC_F3_LHU 3'b101
`define NPC_F3_SB  3'b000
`define NPC_F3_SH  3'b001
`define NPC_F3_SW  3'b010

// alu funct3
`define NPC_F3_ADD  3'b000
`define NPC_F3_SLL  3'b001
`define NPC_F3_SLT  3'b010
`define NPC_F3_SLTU 3'b011
`define NPC_F3_XOR  3'b100
`define NPC_F3_SR   3'b101
`define NPC_F3_OR   3'b110
`define NPC_F3_AND  3'b111

`endif

// ==== npc_exu.sv ====
`timescale 1ns/1ps
`include "npc_defines.svh"
`default_nettype none

module npc_exu (
  input  logic [31:0]      pc,
  input  npc_pkg::decode_t dec,
  input  logic [31:0]      src1,
  input  logic [31:0]      src2,
  input  logic [31:0]      load_data,
  output logic [31:0]      alu_result,
  output logic [31:0]      npc,
  output logic [31:0]      wb_data
);

  import npc_pkg::*;

  logic [31:0] op_a;
  logic [31:0] op_b;
  logic [4:0]  shamt;
  logic [31:0] pc_plus4;
  logic [31:0] pc_target;
  logic        taken;

  assign op_a      = dec.a_is_pc ? pc : src1;
  assign op_b      = dec.b_is_imm ? dec.imm : src2;
  assign shamt     = op_b[4:0];
  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + dec.imm;

  always_comb begin
    case (dec.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_SLL:    alu_result = op_a << shamt;
      ALU_SLT:    alu_result = {31'b0, $signed(op_a) < $signed(op_b)};
      ALU_SLTU:   alu_result = {31'b0, op_a < op_b};
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SRL:    alu_result = op_a >> shamt;
      ALU_SRA:    alu_result = $unsigned($signed(op_a) >>> shamt);
      ALU_OR:     alu_result = op_a | op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = op_a + op_b;
    endcase
  end

  // branches compare the raw register values
  always_comb begin
    case (dec.br_funct3)
      `NPC_F3_BEQ:  taken = (src1 == src2);
      `NPC_F3_BNE:  taken = (src1 != src2);
      `NPC_F3_BLT:  taken = ($signed(src1) < $signed(src2));
      `NPC_F3_BGE:  taken = ($signed(src1) >= $signed(src2));
      `NPC_F3_BLTU: taken = (src1 < src2);
      `NPC_F3_BGEU: taken = (src1 >= src2);
      default:      taken = 1'b0;
    endcase
  end

  always_comb begin
    case (dec.npc_sel)
      NPC_SEQ:    npc = pc_plus4;
      NPC_BRANCH: npc = taken ? pc_target : pc_plus4;
      NPC_JAL:    npc = pc_target;
      NPC_JALR:   npc = {alu_result[31:1], 1'b0};
      default:    npc = pc_plus4;
    endcase
  end

  always_comb begin
    case (dec.wb_sel)
      WB_PC4:  wb_data = pc_plus4;
      WB_LOAD: wb_data = load_data;
      default: wb_data = alu_result;
    endcase
  end

endmodule

`default_nettype wire

// ==== npc_gpr.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_gpr (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1,
  input  logic [4:0]  rs2,
  input  logic [4:0]  rd,
  input  logic        wen,
  input  logic [31:0] wdata,
  output logic [31:0] src1,
  output logic [31:0] src2
);

  logic [31:0] regs [32];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (rd != 5'd0)) begin
      regs[rd] <= wdata;
    end
  end

  // x0 reads as zero
  assign src1 = (rs1 == 5'd0) ? 32'd0 : regs[rs1];
  assign src2 = (rs2 == 5'd0) ? 32'd0 : regs[rs2];

endmodule

`default_nettype wire

// ==== npc_idu.sv ====
`timescale 1ns/1ps
`include "npc_defines.svh"
`default_nettype none

module npc_idu (
  input  logic [31:0]      inst,
  output npc_pkg::decode_t dec
);

  import npc_pkg::*;

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [31:0] imm_i;
  logic [31:0] imm_s;
  logic [31:0] imm_b;
  logic [31:0] imm_u;
  logic [31:0] imm_j;

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt,
                                          input logic is_reg);
    alu_op_e op;
    op = ALU_ADD;
    case (f3)
      `NPC_F3_ADD:  op = (is_reg && alt) ? ALU_SUB : ALU_ADD;
      `NPC_F3_SLL:  op = ALU_SLL;
      `NPC_F3_SLT:  op = ALU_SLT;
      `NPC_F3_SLTU: op = ALU_SLTU;
      `NPC_F3_XOR:  op = ALU_XOR;
      `NPC_F3_SR:   op = alt ? ALU_SRA : ALU_SRL;
      `NPC_F3_OR:   op = ALU_OR;
      `NPC_F3_AND:  op = ALU_AND;
      default:      op = ALU_ADD;
    endcase
    return op;
  endfunction

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {inst[31:12], 12'b0};
  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // anything unrecognised falls through as a no-op
    dec           = '0;
    dec.rs1       = inst[19:15];
    dec.rs2       = inst[24:20];
    dec.rd        = inst[11:7];
    dec.alu_op    = ALU_ADD;
    dec.npc_sel   = NPC_SEQ;
    dec.wb_sel    = WB_ALU;
    dec.mem_size  = MEM_WORD;
    dec.br_funct3 = funct3;
    case (opcode)
      `NPC_OP_LUI: begin
        dec.reg_wen  = 1'b1;
        dec.alu_op   = ALU_PASS_B;
        dec.b_is_imm = 1'b1;
        dec.imm      = imm_u;
      end
      `NPC_OP_AUIPC: begin
        dec.reg_wen  = 1'b1;
        dec.a_is_pc  = 1'b1;
        dec.b_is_imm = 1'b1;
        dec.imm      = imm_u;
      end
      `NPC_OP_JAL: begin
        dec.reg_wen = 1'b1;
        dec.npc_sel = NPC_JAL;
        dec.wb_sel  = WB_PC4;
        dec.imm     = imm_j;
      end
      `NPC_OP_JALR: begin
        dec.reg_wen  = 1'b1;
        dec.npc_sel  = NPC_JALR;
        dec.wb_sel   = WB_PC4;
        dec.b_is_imm = 1'b1;
        dec.imm      = imm_i;
      end
      `NPC_OP_BRANCH: begin
        dec.npc_sel = NPC_BRANCH;
        dec.imm     = imm_b;
      end
      `NPC_OP_LOAD: begin
        dec.reg_wen   = 1'b1;
        dec.wb_sel    = WB_LOAD;
        dec.mem_read  = 1'b1;
        dec.b_is_imm  = 1'b1;
        dec.imm       = imm_i;
        dec.load_sext = ~funct3[2];
        case (funct3)
          `NPC_F3_LB, `NPC_F3_LBU: dec.mem_size = MEM_BYTE;
          `NPC_F3_LH, `NPC_F3_LHU: dec.mem_size = MEM_HALF;
          default:                 dec.mem_size = MEM_WORD;
        endcase
      end
      `NPC_OP_STORE: begin
        dec.mem_write = 1'b1;
        dec.b_is_imm  = 1'b1;
        dec.imm       = imm_s;
        case (funct3)
          `NPC_F3_SB: dec.mem_size = MEM_BYTE;
          `NPC_F3_SH: dec.mem_size = MEM_HALF;
          default:    dec.mem_size = MEM_WORD;
        endcase
      end
      `NPC_OP_IMM: begin
        dec.reg_wen  = 1'b1;
        dec.b_is_imm = 1'b1;
        dec.imm      = imm_i;
        dec.alu_op   = alu_from_f3(funct3, funct7[5], 1'b0);
      end
      `NPC_OP_REG: begin
        dec.reg_wen = 1'b1;
        dec.alu_op  = alu_from_f3(funct3, funct7[5], 1'b1);
      end
      `NPC_OP_SYSTEM: begin
        dec.ebreak = (inst[31:20] == 12'h001) && (funct3 == 3'b000);
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// ==== npc_ifu.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_ifu (
  input  logic        clk,
  input  logic        rst,
  input  logic        fetch,
  input  logic [31:0] pc,
  output logic        imem_en,
  output logic [31:0] imem_addr,
  input  logic [31:0] imem_rdata,
  output logic [31:0] inst
);

  logic        fetch_q;
  logic [31:0] inst_q;

  assign imem_en   = fetch;
  assign imem_addr = pc;

  // marks the cycle where the memory presents the word
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_q <= 1'b0;
    end else begin
      fetch_q <= fetch;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_q) begin
      inst_q <= imem_rdata;
    end
  end

  // fresh word in execute, held copy during memory waits
  assign inst = fetch_q ? imem_rdata : inst_q;

endmodule

`default_nettype wire

// ==== npc_lsu.sv ====
`timescale 1ns/1ps
`default_nettype none

module npc_lsu (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  npc_pkg::decode_t  dec,
  input  logic [31:0]       addr,
  input  logic [31:0]       store_data,
  output npc_pkg::apb_req_t apb_req,
  input  npc_pkg::apb_rsp_t apb_rsp,
  output logic [31:0]       load_data,
  output logic              done
);

  import npc_pkg::*;

  typedef enum logic {
    ST_SETUP,
    ST_ACCESS
  } lsu_state_e;

  lsu_state_e  state;
  logic [3:0]  strb;
  logic [31:0] wdata;
  logic [31:0] shifted;

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_SETUP;
    end else begin
      case (state)
        ST_SETUP:  if (start) state <= ST_ACCESS;
        ST_ACCESS: if (apb_rsp.pready) state <= ST_SETUP;
        default:   state <= ST_SETUP;
      endcase
    end
  end

  // replicate the store data over every lane, strobe picks the right one
  always_comb begin
    case (dec.mem_size)
      MEM_BYTE: begin
        strb  = 4'b0001 << addr[1:0];
        wdata = {4{store_data[7:0]}};
      end
      MEM_HALF: begin
        strb  = 4'b0011 << {addr[1], 1'b0};
        wdata = {2{store_data[15:0]}};
      end
      default: begin
        strb  = 4'b1111;
        wdata = store_data;
      end
    endcase
  end

  // setup phase is the start cycle itself
  always_comb begin
    apb_req.paddr   = {addr[31:2], 2'b00};
    apb_req.psel    = start || (state == ST_ACCESS);
    apb_req.penable = (state == ST_ACCESS);
    apb_req.pwrite  = dec.mem_write;
    apb_req.pwdata  = wdata;
    apb_req.pstrb   = dec.mem_write ? strb : 4'b0000;
  end

  assign done = (state == ST_ACCESS) && apb_rsp.pready;

  assign shifted = apb_rsp.prdata >> {addr[1:0], 3'b000};

  always_comb begin
    case (dec.mem_size)
      MEM_BYTE: load_data = {{24{dec.load_sext & shifted[7]}}, shifted[7:0]};
      MEM_HALF: load_data = {{16{dec.load_sext & shifted[15]}}, shifted[15:0]};
      default:  load_data = apb_rsp.prdata;
    endcase
  end

endmodule

`default_nettype wire

// ==== npc_pkg.sv ====
`default_nettype none

package npc_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

  typedef enum logic [1:0] {
    NPC_SEQ,
    NPC_BRANCH,
    NPC_JAL,
    NPC_JALR
  } npc_sel_e;

  typedef enum logic [1:0] {
    WB_ALU,
    WB_PC4,
    WB_LOAD
  } wb_sel_e;

  typedef enum logic [1:0] {
    MEM_BYTE,
    MEM_HALF,
    MEM_WORD
  } mem_size_e;

  typedef struct packed {
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic        reg_wen;
    alu_op_e     alu_op;
    logic        a_is_pc;
    logic        b_is_imm;
    npc_sel_e    npc_sel;
    logic [2:0]  br_funct3;
    wb_sel_e     wb_sel;
    logic        mem_read;
    logic        mem_write;
    mem_size_e   mem_size;
    logic        load_sext;
    logic        ebreak;
    logic [31:0] imm;
  } decode_t;

  typedef struct packed {
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    logic [3:0]  pstrb;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

endpackage

`default_nettype wire

// ==== npc_vectors.txt ====
# I addr inst | D addr word | T test name | W addr data strb
# W data holds only the enabled lanes, the rest are zero
D 10000040 80017ff0
D 10000030 11223344
I 80000000 100000b7
T alu
I 80000004 fff00113
I 80000008 00415193
I 8000000c 40415213
I 80000010 002032b3
I 80000014 00012333
I 80000018 402183b3
I 8000001c 0030a023
W 10000000 0fffffff f
I 80000020 0040a223
W 10000004 ffffffff f
I 80000024 00628433
I 80000028 0070a423
W 10000008 10000000 f
I 8000002c 0080a623
W 1000000c 00000002 f
T load
I 80000030 04108483
I 80000034 04008503
I 80000038 0430c583
I 8000003c 04209603
I 80000040 0400d683
I 80000044 0090a823
W 10000010 0000007f f
I 80000048 00a0aa23
W 10000014 fffffff0 f
I 8000004c 00b0ac23
W 10000018 00000080 f
I 80000050 00c0ae23
W 1000001c ffff8001 f
I 80000054 02d0a023
W 10000020 00007ff0 f
T store
I 80000058 022088a3
W 10000030 0000ff00 2
I 8000005c 02809923
W 10000030 00020000 c
I 80000060 0300a703
I 80000064 02e0a223
W 10000024 0002ff44 f
T ctrl
I 80000068 00628463
I 8000006c 0220a423
I 80000070 00516463
I 80000074 0250a623
W 1000002c 00000001 f
I 80000078 008007ef
I 8000007c 0220a423
I 80000080 02f0aa23
W 10000034 8000007c f
I 80000084 01078867
I 80000088 0220a423
I 8000008c 0300ac23
W 10000038 80000088 f
I 80000090 00100073

// ==== tb_npc.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_npc;

  import npc_pkg::*;

  logic        clk;
  logic        rst;
  logic        imem_en;
  logic [31:0] imem_addr;
  logic [31:0] imem_rdata;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic        halt;

  logic [31:0] imem [logic [31:0]];
  logic [31:0] dmem [logic [31:0]];
  logic [31:0] rnd_state;
  int          waits;
  int          prog_count;
  bit          loaded;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // untouched words depend on their address
  function automatic logic [31:0] read_word(input logic [31:0] a);
    return dmem.exists(a) ? dmem[a] : (a ^ 32'h5a5a_5a5a);
  endfunction

  npc_core i_npc_core (
    .clk        (clk),
    .rst        (rst),
    .imem_en    (imem_en),
    .imem_addr  (imem_addr),
    .imem_rdata (imem_rdata),
    .apb_req    (apb_req),
    .apb_rsp    (apb_rsp),
    .halt       (halt)
  );

  npc_checker i_npc_checker (
    .clk     (clk),
    .rst     (rst),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp),
    .halt    (halt)
  );

  always #50 clk = ~clk;

  task automatic load_vectors();
    int          fd;
    string       line;
    string       name;
    byte         kind;
    logic [31:0] a;
    logic [31:0] d;
    logic [3:0]  s;
    fd = $fopen("npc_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open npc_vectors.txt");
      $display("TEST FAILED");
      $finish;
    end else begin
      while ($fgets(line, fd)) begin
        kind = line.getc(0);
        if (kind == "I") begin
          void'($sscanf(line, "%c %h %h", kind, a, d));
          imem[a] = d;
          prog_count++;
        end else if (kind == "D") begin
          void'($sscanf(line, "%c %h %h", kind, a, d));
          dmem[a] = d;
        end else if (kind == "T") begin
          void'($sscanf(line, "%c %s", kind, name));
        end else if (kind == "W") begin
          void'($sscanf(line, "%c %h %h %h", kind, a, d, s));
          i_npc_checker.expect_store(name, a, d, s);
        end
      end
      $fclose(fd);
    end
  endtask

  // fetched word appears one cycle after imem_en
  always @(posedge clk) begin
    logic        en_q;
    logic [31:0] addr_q;
    en_q   = imem_en;
    addr_q = imem_addr;
    #1;
    if (en_q) imem_rdata = imem.exists(addr_q) ? imem[addr_q] : 32'h0000_0013;
  end

  // APB slave with 0 to 3 wait states
  always @(posedge clk) begin
    apb_req_t    req;
    logic        rdy;
    logic [31:0] m;
    req = apb_req;
    rdy = apb_rsp.pready;
    #1;
    if (rst) begin
      apb_rsp.pready = 1'b0;
    end else if (req.psel && req.penable && rdy) begin
      if (req.pwrite) begin
        m = {{8{req.pstrb[3]}}, {8{req.pstrb[2]}}, {8{req.pstrb[1]}}, {8{req.pstrb[0]}}};
        dmem[req.paddr] = (read_word(req.paddr) & ~m) | (req.pwdata & m);
      end
      apb_rsp.pready = 1'b0;
    end else if (req.psel) begin
      if (!req.penable) begin
        rnd_state = xorshift(rnd_state);
        waits = rnd_state % 4;
      end else begin
        waits--;
      end
      if (waits <= 0) begin
        apb_rsp.pready = 1'b1;
        apb_rsp.prdata = read_word(req.paddr);
      end
    end
  end

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    imem_rdata = 32'h0;
    apb_rsp    = '0;
    rnd_state  = 32'd44;
    prog_count = 0;
    loaded     = 1'b0;
    load_vectors();
    loaded = 1'b1;
    repeat (4) @(posedge clk);
    #1 rst = 1'b0;
    wait (halt);
    repeat (4) @(posedge clk);
    i_npc_checker.report();
    if (i_npc_checker.errors == 0 && i_npc_checker.fail_count == 0 &&
        i_npc_core.i_npc_asserts.failures == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // every instruction fits in 6 cycles even with 3 wait states
  initial begin
    wait (loaded);
    #(prog_count * 6 * 100 + 5000);
    $display("timeout: the core did not reach ebreak in time");
    $display("TEST FAILED");
    $finish;
  end

endmodule

`default_nettype wire
